//--- p6_backend.f
rtl/p6_pkg.sv
rtl/map_table.sv
rtl/reorder_buffer.sv
rtl/reservation_station.sv
rtl/alu_unit.sv
rtl/arch_regfile.sv
rtl/p6_backend.sv
verification/clock_gen.sv
verification/p6_backend_tb.sv

//--- verification/p6_backend_tb.sv
////////////////////////////////////////////////////////////
// p6 back end testbench
// in-order reference model against out-of-order retirement
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module p6_backend_tb import p6_pkg::*; ();

    // one expected retirement and the edge it was accepted on
    typedef struct packed {
        retire_t     result;
        int unsigned accept_edge;
    } expected_t;

    logic        clock;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    inst_t       in_inst;
    logic        retire_valid;
    retire_t     retire;

    word_t       shadow [num_regs];
    expected_t   expected_q [$];
    logic [31:0] lcg_state = 32'd32;
    int unsigned edge_count = 0;
    int unsigned accepted_count = 0;
    int unsigned retired_count = 0;
    int unsigned stall_count = 0;
    int unsigned error_count = 0;

    clock_gen u_clock_gen (.clock, .reset);

    p6_backend DUT (
        .clock, .reset, .in_valid, .in_ready, .in_inst, .retire_valid, .retire
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits, the low ones of an lcg cycle quickly
    function automatic op_e random_op(input logic allow_li);
        logic [31:0] r;
        r = (next_random() >> 16) % (allow_li ? 5 : 4);
        case (r)
            0:       return op_add;
            1:       return op_sub;
            2:       return op_and;
            3:       return op_xor;
            default: return op_li;
        endcase
    endfunction

    function automatic inst_t make_inst(input op_e op, input reg_idx_t dest,
                                        input reg_idx_t src_a, input reg_idx_t src_b,
                                        input word_t imm);
        inst_t inst;
        inst.op    = op;
        inst.dest  = dest;
        inst.src_a = src_a;
        inst.src_b = src_b;
        inst.imm   = imm;
        return inst;
    endfunction

    // sequential interpreter over the shadow registers
    function automatic retire_t reference_result(input inst_t inst);
        word_t a;
        word_t b;
        word_t value;
        a = shadow[inst.src_a];
        b = shadow[inst.src_b];
        case (inst.op)
            op_add:  value = a + b;
            op_sub:  value = a - b;
            op_and:  value = a & b;
            op_xor:  value = a ^ b;
            default: value = inst.imm;
        endcase
        shadow[inst.dest] = value;
        return '{dest: inst.dest, value: value};
    endfunction

    // hold valid until accepted, then idle for gap cycles
    task automatic send(input inst_t inst, input int unsigned gap);
        in_valid = 1'b1;
        in_inst  = inst;
        do begin
            @(negedge clock);
        end while (!in_ready);
        @(posedge clock);
        #1;
        in_valid = 1'b0;
        in_inst  = '0;
        repeat (gap) begin
            @(posedge clock);
            #1;
        end
    endtask

    // queue drains at the falling edge, look again after the next rise
    task automatic wait_idle();
        while (expected_q.size() != 0) begin
            @(posedge clock);
            #1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // monitor, sampled mid cycle where everything is stable
    ////////////////////////////////////////////////////////////
    always @(posedge clock) edge_count <= edge_count + 1;

    always @(negedge clock) begin : compare_retire
        expected_t item;
        if (!reset) begin
            if (in_valid && !in_ready) stall_count++;
            if (retire_valid) begin
                retired_count++;
                if (expected_q.size() == 0) begin
                    error_count++;
                    $display("at %0t a retirement came with nothing outstanding", $time);
                end else begin
                    item = expected_q.pop_front();
                    if (retire.dest != item.result.dest) begin
                        error_count++;
                        $display("FAILED t=%0t: dest %0d, expected %0d", $time,
                                 retire.dest, item.result.dest);
                    end
                    if (retire.value != item.result.value) begin
                        error_count++;
                        $display("FAILED t=%0t: r%0d value %h, expected %h", $time,
                                 retire.dest, retire.value, item.result.value);
                    end
                    // complete two edges after acceptance at the earliest
                    if (edge_count < item.accept_edge + 2) begin
                        error_count++;
                        $display("at %0t an instruction retired too soon after acceptance",
                                 $time);
                    end
                end
            end
            // transfer happens on the coming edge
            if (in_valid && in_ready) begin
                item.result      = reference_result(in_inst);
                item.accept_edge = edge_count + 1;
                expected_q.push_back(item);
                accepted_count++;
            end
            if (expected_q.size() > rob_depth) begin
                error_count++;
                $display("at %0t more than %0d instructions are in flight", $time, rob_depth);
            end
        end
    end

    // 600 instructions at 20 cycles of 100 ns each
    initial begin : watchdog
        #(600 * 20 * 100);
        $display("watchdog expired at %0t, the DUT stopped making progress", $time);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    initial begin : stimulus
        reg_idx_t    prev;
        reg_idx_t    dest;
        int unsigned gap;
        in_valid = 1'b0;
        in_inst  = '0;
        for (int r = 0; r < num_regs; r++) shadow[r] = '0;
        wait (reset === 1'b0);
        @(negedge clock);
        if (!in_ready || retire_valid) begin
            error_count++;
            $display("after reset in_ready was low or retire_valid was high");
        end
        @(posedge clock);
        #1;
        // one immediate per register, back to back
        for (int r = 0; r < num_regs; r++) begin
            send(make_inst(op_li, reg_idx_t'(r), '0, '0, next_random()), 0);
        end
        wait_idle();
        // raw chain with waw overwrites, gaps vary the operand source
        prev = 4'd1;
        for (int i = 0; i < 40; i++) begin
            dest = reg_idx_t'(1 + (next_random() >> 16) % 4);
            send(make_inst(random_op(1'b0), dest, prev, reg_idx_t'(next_random() >> 20), '0),
                 (next_random() >> 16) % 4);
            prev = dest;
        end
        wait_idle();
        // short chain on r1, then work that does not depend on it
        for (int g = 0; g < 3; g++) begin
            for (int i = 0; i < 4; i++) begin
                send(make_inst(op_add, 4'd1, 4'd1, 4'd2, '0), 0);
            end
            send(make_inst(op_li, 4'd12, '0, '0, next_random()), 0);
            send(make_inst(op_xor, 4'd13, 4'd5, 4'd6, '0), 0);
            send(make_inst(op_and, 4'd14, 4'd7, 4'd8, '0), 0);
            send(make_inst(op_sub, 4'd15, 4'd9, 4'd10, '0), 0);
        end
        wait_idle();
        // valid held high on a dependent stream
        stall_count = 0;
        prev = 4'd3;
        for (int i = 0; i < 48; i++) begin
            dest = reg_idx_t'(next_random() >> 20);
            send(make_inst(random_op(1'b0), dest, prev, reg_idx_t'(next_random() >> 24), '0), 0);
            prev = dest;
        end
        if (stall_count == 0) begin
            error_count++;
            $display("in_ready never dropped while valid was held high");
        end
        wait_idle();
        // random program with random idle gaps
        for (int i = 0; i < 400; i++) begin
            gap = ((next_random() >> 16) % 4 == 0) ? (next_random() >> 16) % 3 : 0;
            send(make_inst(random_op(1'b1), reg_idx_t'(next_random() >> 20),
                           reg_idx_t'(next_random() >> 20), reg_idx_t'(next_random() >> 20),
                           next_random()), gap);
        end
        wait_idle();
        // stray retirements would show up here
        repeat (10) @(posedge clock);
        if (accepted_count != retired_count) begin
            error_count++;
            $display("accepted and retired counts differ");
        end
        $display("accepted %0d, retired %0d, errors %0d",
                 accepted_count, retired_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- verification/clock_gen.sv
////////////////////////////////////////////////////////////
// testbench clock and reset source
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module clock_gen (
    output logic clock,
    output logic reset
);

    // 100 ns period
    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // held high for three rising edges, released just after
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clock);
        #1 reset = 1'b0;
    end

endmodule

//--- rtl/p6_backend.sv
////////////////////////////////////////////////////////////
// p6 style out-of-order back end
// rename, rob, reservation station, alu and register file
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module p6_backend import p6_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    in_valid,
    output logic    in_ready,
    input  inst_t   in_inst,
    output logic    retire_valid,
    output retire_t retire
);

    logic     dispatch;
    logic     rob_full;
    logic     rs_free;
    rob_tag_t alloc_tag;
    rob_tag_t retire_tag;
    map_t     map_a;
    map_t     map_b;
    word_t    reg_a;
    word_t    reg_b;
    operand_t operand_a;
    operand_t operand_b;
    logic     issue_valid;
    issue_t   issue;
    cdb_t     cdb;

    ////////////////////////////////////////////////////////////
    // dispatch handshake
    ////////////////////////////////////////////////////////////

    // room in both rob and rs, never looks at in_valid
    assign in_ready = !rob_full && rs_free;
    assign dispatch = in_valid && in_ready;

    map_table u_map_table (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .dest         (in_inst.dest),
        .alloc_tag    (alloc_tag),
        .src_a        (in_inst.src_a),
        .src_b        (in_inst.src_b),
        .map_a        (map_a),
        .map_b        (map_b),
        .retire_valid (retire_valid),
        .retire_dest  (retire.dest),
        .retire_tag   (retire_tag)
    );

    reorder_buffer u_rob (
        .clock, .reset, .dispatch,
        .inst         (in_inst),
        .map_a, .map_b, .reg_a, .reg_b, .cdb,
        .alloc_tag, .full (rob_full),
        .operand_a, .operand_b,
        .retire_valid, .retire, .retire_tag
    );

    reservation_station u_rs (
        .clock, .reset, .dispatch,
        .op           (in_inst.op),
        .tag          (alloc_tag),
        .operand_a, .operand_b, .cdb,
        .free         (rs_free),
        .issue_valid, .issue
    );

    // alu output register drives the cdb
    alu_unit u_alu (
        .clock, .reset, .issue_valid, .issue, .cdb
    );

    arch_regfile u_regfile (
        .clock, .reset,
        .src_a        (in_inst.src_a),
        .src_b        (in_inst.src_b),
        .reg_a, .reg_b, .retire_valid, .retire
    );

endmodule

//--- rtl/arch_regfile.sv
////////////////////////////////////////////////////////////
// architectural register file
// committed state, written only at retirement
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module arch_regfile import p6_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  reg_idx_t src_a,
    input  reg_idx_t src_b,
    output word_t    reg_a,
    output word_t    reg_b,
    input  logic     retire_valid,
    input  retire_t  retire
);

    word_t regs [num_regs];

    // old value during a write, rob covers the new one
    assign reg_a = regs[src_a];
    assign reg_b = regs[src_b];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (retire_valid) begin
            regs[retire.dest] <= retire.value;
        end
    end

endmodule

//--- rtl/alu_unit.sv
////////////////////////////////////////////////////////////
// integer alu
// one registered stage, its output register is the cdb
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module alu_unit import p6_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  logic   issue_valid,
    input  issue_t issue,
    output cdb_t   cdb
);

    word_t result;

    always_comb begin
        case (issue.op)
            op_add:  result = issue.a + issue.b;
            op_sub:  result = issue.a - issue.b;
            op_and:  result = issue.a & issue.b;
            op_xor:  result = issue.a ^ issue.b;
            // immediate already sits in a
            op_li:   result = issue.a;
            default: result = issue.a;
        endcase
    end

    // new request every cycle, nothing stalls
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cdb <= '0;
        end else begin
            cdb.valid <= issue_valid;
            cdb.tag   <= issue.tag;
            cdb.value <= result;
        end
    end

endmodule

//--- rtl/reservation_station.sv
////////////////////////////////////////////////////////////
// reservation station
// holds operand-waiting work and issues the lowest ready slot
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module reservation_station import p6_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     dispatch,
    input  op_e      op,
    input  rob_tag_t tag,
    input  operand_t operand_a,
    input  operand_t operand_b,
    input  cdb_t     cdb,
    output logic     free,
    output logic     issue_valid,
    output issue_t   issue
);

    typedef logic [$clog2(rs_depth)-1:0] rs_idx_t;

    typedef struct packed {
        logic     valid;
        op_e      op;
        rob_tag_t tag;
        operand_t a;
        operand_t b;
    } rs_slot_t;

    rs_slot_t slots [rs_depth];
    rs_idx_t  issue_idx;
    rs_idx_t  alloc_idx;

    ////////////////////////////////////////////////////////////
    // select
    ////////////////////////////////////////////////////////////

    // walk downward so the lowest index wins
    always_comb begin
        issue_valid = 1'b0;
        issue_idx   = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (slots[i].valid && slots[i].a.ready && slots[i].b.ready) begin
                issue_valid = 1'b1;
                issue_idx   = rs_idx_t'(i);
            end
        end
    end

    // the slot issuing now counts as free
    always_comb begin
        free      = 1'b0;
        alloc_idx = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!slots[i].valid || (issue_valid && (issue_idx == rs_idx_t'(i)))) begin
                free      = 1'b1;
                alloc_idx = rs_idx_t'(i);
            end
        end
    end

    assign issue.op = slots[issue_idx].op;
    assign issue.tag = slots[issue_idx].tag;
    assign issue.a = slots[issue_idx].a.value;
    assign issue.b = slots[issue_idx].b.value;

    ////////////////////////////////////////////////////////////
    // slot update
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < rs_depth; i++) begin
                slots[i] <= '0;
            end
        end else begin
            // wakeup from the bus
            for (int i = 0; i < rs_depth; i++) begin
                if (slots[i].valid && cdb.valid) begin
                    if (!slots[i].a.ready && (slots[i].a.tag == cdb.tag)) begin
                        slots[i].a.ready <= 1'b1;
                        slots[i].a.value <= cdb.value;
                    end
                    if (!slots[i].b.ready && (slots[i].b.tag == cdb.tag)) begin
                        slots[i].b.ready <= 1'b1;
                        slots[i].b.value <= cdb.value;
                    end
                end
            end
            if (issue_valid) begin
                slots[issue_idx].valid <= 1'b0;
            end
            // refill wins over the issue clear on the same slot
            if (dispatch) begin
                slots[alloc_idx] <= '{valid: 1'b1, op: op, tag: tag,
                                      a: operand_a, b: operand_b};
            end
        end
    end

    // top must gate dispatch with free
    a_dispatch_has_slot: assert property (
        @(posedge clock) disable iff (reset)
        dispatch |-> free
    );

endmodule

//--- rtl/reorder_buffer.sv
////////////////////////////////////////////////////////////
// reorder buffer
// in-order record of dispatched work, result capture, retire
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module reorder_buffer import p6_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     dispatch,
    input  inst_t    inst,
    input  map_t     map_a,
    input  map_t     map_b,
    input  word_t    reg_a,
    input  word_t    reg_b,
    input  cdb_t     cdb,
    output rob_tag_t alloc_tag,
    output logic     full,
    output operand_t operand_a,
    output operand_t operand_b,
    output logic     retire_valid,
    output retire_t  retire,
    output rob_tag_t retire_tag
);

    rob_entry_t entries [rob_depth];
    rob_tag_t   head;
    rob_tag_t   tail;
    // one wider than a tag, full at rob_depth
    logic [$clog2(rob_depth):0] count;

    ////////////////////////////////////////////////////////////
    // operand resolution
    ////////////////////////////////////////////////////////////

    // register file, then rob entry, then the bus this cycle
    function automatic operand_t resolve(
        input map_t       src_map,
        input word_t      reg_value,
        input rob_entry_t entry,
        input cdb_t       bus
    );
        operand_t result;
        result.ready = 1'b1;
        result.tag   = src_map.tag;
        result.value = reg_value;
        if (src_map.busy) begin
            if (entry.complete) begin
                result.value = entry.value;
            end else if (bus.valid && (bus.tag == src_map.tag)) begin
                // result lands on the same edge as dispatch
                result.value = bus.value;
            end else begin
                result.ready = 1'b0;
                result.value = '0;
            end
        end
        return result;
    endfunction

    always_comb begin
        operand_a = resolve(map_a, reg_a, entries[map_a.tag], cdb);
        operand_b = resolve(map_b, reg_b, entries[map_b.tag], cdb);
        // load immediate has no register sources
        if (inst.op == op_li) begin
            operand_a = '{ready: 1'b1, tag: '0, value: inst.imm};
            operand_b = '{ready: 1'b1, tag: '0, value: '0};
        end
    end

    ////////////////////////////////////////////////////////////
    // status and retire
    ////////////////////////////////////////////////////////////
    assign alloc_tag    = tail;
    assign full         = (count == rob_depth);
    assign retire_valid = entries[head].busy && entries[head].complete;
    assign retire.dest  = entries[head].dest;
    assign retire.value = entries[head].value;
    assign retire_tag   = head;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < rob_depth; i++) begin
                entries[i] <= '0;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // capture by direct index, tag is the slot number
            if (cdb.valid) begin
                entries[cdb.tag].complete <= 1'b1;
                entries[cdb.tag].value    <= cdb.value;
            end
            if (retire_valid) begin
                entries[head].busy     <= 1'b0;
                entries[head].complete <= 1'b0;
                head <= head + 1'b1;
            end
            if (dispatch) begin
                entries[tail] <= '{busy: 1'b1, complete: 1'b0, dest: inst.dest, value: '0};
                tail <= tail + 1'b1;
            end
            // both may happen together
            case ({dispatch, retire_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    a_alloc_free_slot: assert property (
        @(posedge clock) disable iff (reset)
        dispatch |-> !entries[tail].busy
    );

    // alu result must belong to a live, unfinished entry
    a_cdb_live_tag: assert property (
        @(posedge clock) disable iff (reset)
        cdb.valid |-> (entries[cdb.tag].busy && !entries[cdb.tag].complete)
    );

endmodule

//--- rtl/map_table.sv
////////////////////////////////////////////////////////////
// rename map table
// points each architectural register at its newest rob tag
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module map_table import p6_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     dispatch,
    input  reg_idx_t dest,
    input  rob_tag_t alloc_tag,
    input  reg_idx_t src_a,
    input  reg_idx_t src_b,
    output map_t     map_a,
    output map_t     map_b,
    input  logic     retire_valid,
    input  reg_idx_t retire_dest,
    input  rob_tag_t retire_tag
);

    map_t table_q [num_regs];
    logic clear_hit;

    // source lookup sees the state before this cycle's rename
    assign map_a = table_q[src_a];
    assign map_b = table_q[src_b];

    // clear only if no younger writer took the register over
    assign clear_hit = retire_valid
                     && table_q[retire_dest].busy
                     && (table_q[retire_dest].tag == retire_tag)
                     && !(dispatch && (dest == retire_dest));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                table_q[i] <= '0;
            end
        end else begin
            if (clear_hit) begin
                table_q[retire_dest].busy <= 1'b0;
            end
            // newest producer of dest
            if (dispatch) begin
                table_q[dest] <= '{busy: 1'b1, tag: alloc_tag};
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // the tag being handed out must never be the one leaving
    // the rob, which would happen only if dispatch ignored full
    a_no_tag_reuse: assert property (
        @(posedge clock) disable iff (reset)
        (dispatch && retire_valid) |-> (alloc_tag != retire_tag)
    );

endmodule

//--- rtl/p6_pkg.sv
////////////////////////////////////////////////////////////
// p6 back end shared definitions
// sizes, opcodes and the packed records passed between blocks
////////////////////////////////////////////////////////////
package p6_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    // architectural register count
    localparam int num_regs = 16;
    // operand and result width
    localparam int data_width = 32;
    // reorder buffer entries, a power of two so pointers wrap
    localparam int rob_depth = 8;
    // reservation station slots
    localparam int rs_depth = 4;

    typedef logic [$clog2(num_regs)-1:0] reg_idx_t;
    typedef logic [data_width-1:0] word_t;
    typedef logic [$clog2(rob_depth)-1:0] rob_tag_t;

    ////////////////////////////////////////////////////////////
    // operations
    ////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_xor = 3'd3,
        op_li  = 3'd4
    } op_e;

    // decoded instruction as it arrives in program order
    typedef struct packed {
        op_e      op;
        reg_idx_t dest;
        reg_idx_t src_a;
        reg_idx_t src_b;
        // only read by op_li
        word_t    imm;
    } inst_t;

    // rename lookup result
    typedef struct packed {
        logic     busy;
        rob_tag_t tag;
    } map_t;

    // value when ready, else the producing tag
    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        word_t    value;
    } operand_t;

    // one request into the alu
    typedef struct packed {
        op_e      op;
        rob_tag_t tag;
        word_t    a;
        word_t    b;
    } issue_t;

    // common data bus
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } cdb_t;

    // committed write to the register file
    typedef struct packed {
        reg_idx_t dest;
        word_t    value;
    } retire_t;

    // one reorder buffer slot
    typedef struct packed {
        logic     busy;
        logic     complete;
        reg_idx_t dest;
        word_t    value;
    } rob_entry_t;

endpackage
